// ==== masked_mem.f ====
noc_pkg.sv
mem_pkg.sv
noc_msg_type_splitter.sv
masked_mem_rd_ctrl.sv
masked_mem_wr_ctrl.sv
masked_mem_datap.sv
masked_mem_controller.sv
tb_clk_gen.sv
tb_mem_model.sv
masked_mem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the masked memory controller testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module masked_mem_tb -f masked_mem.f -o masked_mem_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/masked_mem_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0

// ==== masked_mem_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module masked_mem_tb;

    typedef struct packed {
        noc_pkg::msg_type_t     msg_type;
        noc_pkg::byte_addr_t    addr;
        noc_pkg::byte_cnt_t     byte_cnt;
        logic [7:0]             pattern;
        noc_pkg::node_id_t      node_id;
        logic [7:0]             words;
    } req_entry_t;

    localparam int NUM_REQS        = 12;
    localparam int WATCHDOG_CYCLES = NUM_REQS * 200 + 16;

    logic                   clk;
    logic                   arst_n;
    logic                   req_val;
    noc_pkg::flit_t         req_flit;
    logic                   req_rdy;
    logic                   resp_val;
    noc_pkg::flit_t         resp_flit;
    logic                   resp_rdy;
    logic                   wr_resp_val;
    noc_pkg::flit_t         wr_resp_flit;
    logic                   wr_resp_rdy;
    mem_pkg::mem_req_t      mem_req;
    logic                   mem_write_en;
    logic                   mem_read_en;
    logic                   mem_rdy;
    logic                   mem_rd_val;
    mem_pkg::mem_word_t     mem_rd_data;
    logic                   mem_rd_rdy;

    req_entry_t             reqs [NUM_REQS];
    mem_pkg::mem_word_t     shadow [0:65535];
    noc_pkg::flit_t         exp_resp [$];
    noc_pkg::flit_t         exp_wr_resp [$];
    integer                 seed;

    tb_clk_gen clk_gen (
         .clk       (clk    )
        ,.arst_n    (arst_n )
    );

    masked_mem_controller uut (
         .clk           (clk            )
        ,.arst_n        (arst_n         )
        ,.req_val       (req_val        )
        ,.req_flit      (req_flit       )
        ,.req_rdy       (req_rdy        )
        ,.resp_val      (resp_val       )
        ,.resp_flit     (resp_flit      )
        ,.resp_rdy      (resp_rdy       )
        ,.wr_resp_val   (wr_resp_val    )
        ,.wr_resp_flit  (wr_resp_flit   )
        ,.wr_resp_rdy   (wr_resp_rdy    )
        ,.mem_req       (mem_req        )
        ,.mem_write_en  (mem_write_en   )
        ,.mem_read_en   (mem_read_en    )
        ,.mem_rdy       (mem_rdy        )
        ,.mem_rd_val    (mem_rd_val     )
        ,.mem_rd_data   (mem_rd_data    )
        ,.mem_rd_rdy    (mem_rd_rdy     )
    );

    tb_mem_model mem_model (
         .clk           (clk            )
        ,.mem_req       (mem_req        )
        ,.mem_write_en  (mem_write_en   )
        ,.mem_read_en   (mem_read_en    )
        ,.mem_rdy       (mem_rdy        )
        ,.mem_rd_val    (mem_rd_val     )
        ,.mem_rd_data   (mem_rd_data    )
        ,.mem_rd_rdy    (mem_rd_rdy     )
    );

    // ----------------------------------------------------------
    // Request table: type, addr, byte_cnt, pattern, requester, words
    // ----------------------------------------------------------
    initial begin
        reqs[0]  = '{noc_pkg::MSG_STORE, 32'h0000_0100, 8'd24,  8'h01, 8'h0a, 8'd3};
        reqs[1]  = '{noc_pkg::MSG_LOAD,  32'h0000_0100, 8'd24,  8'h00, 8'h0a, 8'd3};
        reqs[2]  = '{noc_pkg::MSG_STORE, 32'h0000_0203, 8'd3,   8'h02, 8'h0b, 8'd1};
        reqs[3]  = '{noc_pkg::MSG_LOAD,  32'h0000_0200, 8'd16,  8'h00, 8'h00, 8'd2};
        reqs[4]  = '{8'h7f,              32'h0000_0000, 8'd16,  8'h03, 8'h0c, 8'd2};
        reqs[5]  = '{noc_pkg::MSG_STORE, 32'h0000_030d, 8'd20,  8'h04, 8'h00, 8'd4};
        reqs[6]  = '{noc_pkg::MSG_LOAD,  32'h0000_0308, 8'd32,  8'h00, 8'h0d, 8'd4};
        reqs[7]  = '{noc_pkg::MSG_LOAD,  32'h0000_050f, 8'd2,   8'h00, 8'h0e, 8'd2};
        reqs[8]  = '{noc_pkg::MSG_STORE, 32'h0000_05f8, 8'd255, 8'h05, 8'h0f, 8'd32};
        reqs[9]  = '{noc_pkg::MSG_LOAD,  32'h0000_05f8, 8'd255, 8'h00, 8'h00, 8'd32};
        reqs[10] = '{noc_pkg::MSG_STORE, 32'h0000_0107, 8'd2,   8'h06, 8'h0a, 8'd2};
        reqs[11] = '{noc_pkg::MSG_LOAD,  32'h0000_0100, 8'd24,  8'h00, 8'h0a, 8'd3};
    end

    task automatic stop_on_error();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got == exp) else begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    // Lanes of a word whose byte address falls inside the request range.
    function automatic mem_pkg::byte_en_t lane_mask(input noc_pkg::byte_addr_t addr,
                                                    input noc_pkg::byte_cnt_t cnt,
                                                    input int word);
        mem_pkg::byte_en_t mask;
        int                byte_addr;
        mask = '0;
        for (int b = 0; b < mem_pkg::WORD_BYTES; b++) begin
            byte_addr = word * mem_pkg::WORD_BYTES + b;
            mask[b]   = (byte_addr >= addr) && (byte_addr < addr + cnt);
        end
        return mask;
    endfunction

    function automatic mem_pkg::mem_word_t payload_word(input logic [7:0] pattern,
                                                        input int k);
        return {4{pattern, 8'(k)}} ^ 64'h0f1e_2d3c_4b5a_6978;
    endfunction

    // Called on a falling edge; returns on the falling edge after the transfer.
    task automatic send_flit(input noc_pkg::flit_t flit);
        logic taken;
        taken    = 1'b0;
        req_val  = 1'b1;
        req_flit = flit;
        while (!taken) begin
            #2;
            taken = req_rdy;
            @(negedge clk);
        end
        req_val = 1'b0;
    endtask

    task automatic run_request(input req_entry_t r);
        noc_pkg::noc_hdr_t  hdr;
        noc_pkg::node_id_t  dest;
        mem_pkg::byte_en_t  be;
        mem_pkg::mem_word_t data;
        int                 first;
        hdr.msg_type = r.msg_type;
        hdr.msg_len  = (r.msg_type == noc_pkg::MSG_LOAD) ? 8'd0 : r.words;
        hdr.node_id  = r.node_id;
        hdr.byte_cnt = r.byte_cnt;
        hdr.addr     = r.addr;
        first        = r.addr / mem_pkg::WORD_BYTES;
        // Requests from node 0 are answered to this tile's own id.
        dest         = (r.node_id == 8'h00) ? noc_pkg::NODE_ID : r.node_id;
        if (r.msg_type == noc_pkg::MSG_LOAD) begin
            exp_resp.push_back({noc_pkg::MSG_LOAD_RESP, r.words, dest, r.byte_cnt, r.addr});
            for (int k = 0; k < r.words; k++) begin
                exp_resp.push_back(shadow[first + k]);
            end
            send_flit(hdr);
        end else begin
            if (r.msg_type == noc_pkg::MSG_STORE) begin
                for (int k = 0; k < r.words; k++) begin
                    be   = lane_mask(r.addr, r.byte_cnt, first + k);
                    data = payload_word(r.pattern, k);
                    for (int b = 0; b < mem_pkg::WORD_BYTES; b++) begin
                        if (be[b]) begin
                            shadow[first + k][8*b +: 8] = data[8*b +: 8];
                        end
                    end
                end
                exp_wr_resp.push_back({noc_pkg::MSG_STORE_RESP, 8'd0, dest, r.byte_cnt,
                                       r.addr});
            end
            // Unknown types go out the same way and must vanish in the splitter.
            send_flit(hdr);
            for (int k = 0; k < r.words; k++) begin
                send_flit(payload_word(r.pattern, k));
            end
        end
    endtask

    // ----------------------------------------------------------
    // Response ports with random back-pressure
    // ----------------------------------------------------------
    initial begin
        seed        = 32'h782a_0590;
        resp_rdy    = 1'b0;
        wr_resp_rdy = 1'b0;
        wait (arst_n);
        forever begin
            @(negedge clk);
            resp_rdy    = ($random(seed) & 3) != 0;
            wr_resp_rdy = ($random(seed) & 1) != 0;
            #2;
            if (resp_val && resp_rdy) begin
                assert (exp_resp.size() != 0)
                    check_value("resp_flit", resp_flit, exp_resp.pop_front());
                else begin
                    $display("error: resp_flit %h arrived with no flit expected", resp_flit);
                    stop_on_error();
                end
            end
            if (wr_resp_val && wr_resp_rdy) begin
                assert (exp_wr_resp.size() != 0)
                    check_value("wr_resp_flit", wr_resp_flit, exp_wr_resp.pop_front());
                else begin
                    $display("error: wr_resp_flit %h arrived with no flit expected",
                             wr_resp_flit);
                    stop_on_error();
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("error: the run timed out before all responses arrived");
        stop_on_error();
    end

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        req_val  = 1'b0;
        req_flit = '0;
        wait (arst_n);
        for (int i = 0; i < 65536; i++) begin
            shadow[i] = mem_model.mem[i];
        end
        @(negedge clk);
        #2;
        check_value("resp_val", resp_val, 64'd0);
        check_value("wr_resp_val", wr_resp_val, 64'd0);
        check_value("mem_write_en", mem_write_en, 64'd0);
        check_value("mem_read_en", mem_read_en, 64'd0);
        @(negedge clk);
        for (int t = 0; t < NUM_REQS; t++) begin
            run_request(reqs[t]);
        end
        while (exp_resp.size() != 0 || exp_wr_resp.size() != 0) begin
            @(negedge clk);
        end
        // Words outside every store range must still hold their fill value.
        for (int i = 0; i < 65536; i++) begin
            check_value($sformatf("mem[%h]", 16'(i)), mem_model.mem[i], shadow[i]);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model (
     input  logic                   clk
    ,input  mem_pkg::mem_req_t      mem_req
    ,input  logic                   mem_write_en
    ,input  logic                   mem_read_en
    ,output logic                   mem_rdy
    ,output logic                   mem_rd_val
    ,output mem_pkg::mem_word_t     mem_rd_data
    ,input  logic                   mem_rd_rdy
);
    mem_pkg::mem_word_t mem [0:65535];
    mem_pkg::mem_word_t word;
    mem_pkg::mem_addr_t rd_addr;
    logic [1:0]         rd_wait;
    integer             seed;

    initial begin
        seed        = 32'h782a_0590;
        rd_addr     = '0;
        rd_wait     = 2'd0;
        mem_rdy     = 1'b0;
        mem_rd_val  = 1'b0;
        mem_rd_data = '0;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = {16'(i) ^ 16'hbeef, 16'(i), ~16'(i), 16'(i) * 16'd37};
        end
    end

    // Outputs change on the falling edge. The handshakes of the coming rising
    // edge are settled 2 ns later, once every input of the cycle is driven.
    always begin
        @(negedge clk);
        mem_rdy    = ($random(seed) & 3) != 0;
        mem_rd_val = rd_wait == 2'd1;
        if (mem_rd_val) begin
            mem_rd_data = mem[rd_addr];
        end
        if (rd_wait == 2'd2) begin
            rd_wait = 2'd1;
        end
        #2;
        if (mem_write_en && mem_rdy) begin
            word = mem[mem_req.addr];
            for (int b = 0; b < mem_pkg::WORD_BYTES; b++) begin
                if (mem_req.byte_en[b]) begin
                    word[8*b +: 8] = mem_req.wr_data[8*b +: 8];
                end
            end
            mem[mem_req.addr] = word;
        end
        // Data of an accepted read is valid two rising edges later.
        if (mem_read_en && mem_rdy) begin
            rd_addr = mem_req.addr;
            rd_wait = 2'd2;
        end
        if (mem_rd_val && mem_rd_rdy) begin
            rd_wait = 2'd0;
        end
    end

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
     output logic   clk
    ,output logic   arst_n
);
    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        repeat (8) @(posedge clk);
        // Release on a falling edge so that no rising edge sees it change.
        @(negedge clk);
        arst_n = 1'b1;
    end

    always #4 clk = ~clk;

endmodule

`default_nettype wire

// ==== masked_mem_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

module masked_mem_controller (
     input  logic                   clk
    ,input  logic                   arst_n

    ,input  logic                   req_val
    ,input  noc_pkg::flit_t         req_flit
    ,output logic                   req_rdy

    ,output logic                   resp_val
    ,output noc_pkg::flit_t         resp_flit
    ,input  logic                   resp_rdy

    ,output logic                   wr_resp_val
    ,output noc_pkg::flit_t         wr_resp_flit
    ,input  logic                   wr_resp_rdy

    ,output mem_pkg::mem_req_t      mem_req
    ,output logic                   mem_write_en
    ,output logic                   mem_read_en
    ,input  logic                   mem_rdy
    ,input  logic                   mem_rd_val
    ,input  mem_pkg::mem_word_t     mem_rd_data
    ,output logic                   mem_rd_rdy
);
    logic               split_rd_val;
    logic               split_rd_rdy;
    noc_pkg::flit_t     rd_flit;
    logic               rd_val;
    logic               rd_rdy;

    logic               split_wr_val;
    logic               split_wr_rdy;
    noc_pkg::flit_t     wr_flit;
    logic               wr_val;
    logic               wr_rdy;

    logic               rd_in_progress;
    logic               wr_in_progress;

    logic               rd_store_hdr;
    logic               rd_next_word;
    logic               wr_store_hdr;
    logic               wr_next_word;
    logic               store_hdr;
    logic               next_word;
    logic               hdr_out;
    logic               first_word;
    logic               last_word;
    noc_pkg::flit_t     datap_flit;

    // ----------------------------------------------------------
    // Lockout between the load and store sides
    // ----------------------------------------------------------
    assign rd_val       = split_rd_val & ~wr_in_progress;
    assign split_rd_rdy = rd_rdy & ~wr_in_progress;
    assign wr_val       = split_wr_val & ~rd_in_progress;
    assign split_wr_rdy = wr_rdy & ~rd_in_progress;

    assign datap_flit = wr_val ? wr_flit : rd_flit;
    assign store_hdr  = rd_store_hdr | wr_store_hdr;
    assign next_word  = rd_next_word | wr_next_word;

    noc_msg_type_splitter splitter (
         .clk       (clk            )
        ,.arst_n    (arst_n         )
        ,.in_val    (req_val        )
        ,.in_flit   (req_flit       )
        ,.in_rdy    (req_rdy        )
        ,.rd_val    (split_rd_val   )
        ,.rd_flit   (rd_flit        )
        ,.rd_rdy    (split_rd_rdy   )
        ,.wr_val    (split_wr_val   )
        ,.wr_flit   (wr_flit        )
        ,.wr_rdy    (split_wr_rdy   )
    );

    masked_mem_rd_ctrl rd_ctrl (
         .clk               (clk            )
        ,.arst_n            (arst_n         )
        ,.req_val           (rd_val         )
        ,.req_rdy           (rd_rdy         )
        ,.resp_val          (resp_val       )
        ,.resp_rdy          (resp_rdy       )
        ,.mem_read_en       (mem_read_en    )
        ,.mem_rdy           (mem_rdy        )
        ,.mem_rd_val        (mem_rd_val     )
        ,.mem_rd_rdy        (mem_rd_rdy     )
        ,.rd_in_progress    (rd_in_progress )
        ,.store_hdr         (rd_store_hdr   )
        ,.next_word         (rd_next_word   )
        ,.hdr_out           (hdr_out        )
        ,.last_word         (last_word      )
    );

    masked_mem_wr_ctrl wr_ctrl (
         .clk               (clk            )
        ,.arst_n            (arst_n         )
        ,.req_val           (wr_val         )
        ,.req_rdy           (wr_rdy         )
        ,.mem_write_en      (mem_write_en   )
        ,.mem_rdy           (mem_rdy        )
        ,.wr_resp_val       (wr_resp_val    )
        ,.wr_resp_rdy       (wr_resp_rdy    )
        ,.wr_in_progress    (wr_in_progress )
        ,.store_hdr         (wr_store_hdr   )
        ,.next_word         (wr_next_word   )
        ,.last_word         (last_word      )
    );

    masked_mem_datap datap (
         .clk           (clk            )
        ,.arst_n        (arst_n         )
        ,.in_flit       (datap_flit     )
        ,.store_hdr     (store_hdr      )
        ,.next_word     (next_word      )
        ,.hdr_out       (hdr_out        )
        ,.mem_rd_data   (mem_rd_data    )
        ,.mem_req       (mem_req        )
        ,.resp_flit     (resp_flit      )
        ,.wr_resp_flit  (wr_resp_flit   )
        ,.first_word    (first_word     )
        ,.last_word     (last_word      )
    );

    // A header taken by either controller starts the datapath on its first word.
    a_hdr_first: assert property (@(posedge clk) disable iff (!arst_n)
        store_hdr |=> first_word);

endmodule

`default_nettype wire

// ==== masked_mem_datap.sv ====
`timescale 1ns/1ns
`default_nettype none

module masked_mem_datap (
     input  logic                   clk
    ,input  logic                   arst_n

    ,input  noc_pkg::flit_t         in_flit

    ,input  logic                   store_hdr
    ,input  logic                   next_word
    ,input  logic                   hdr_out

    ,input  mem_pkg::mem_word_t     mem_rd_data
    ,output mem_pkg::mem_req_t      mem_req

    ,output noc_pkg::flit_t         resp_flit
    ,output noc_pkg::flit_t         wr_resp_flit

    ,output logic                   first_word
    ,output logic                   last_word
);
    noc_pkg::noc_hdr_t      in_hdr;
    noc_pkg::noc_hdr_t      hdr_q;
    noc_pkg::noc_hdr_t      ld_resp_hdr;
    noc_pkg::noc_hdr_t      st_resp_hdr;
    noc_pkg::node_id_t      dest_id;
    noc_pkg::msg_len_t      words_left;
    noc_pkg::byte_addr_t    last_byte;
    mem_pkg::mem_addr_t     word_addr;
    mem_pkg::lane_t         lo_lane;
    mem_pkg::lane_t         hi_lane;
    mem_pkg::byte_en_t      first_mask;
    mem_pkg::byte_en_t      last_mask;
    logic                   first_q;

    // Number of memory words touched by a request.
    function automatic noc_pkg::msg_len_t word_count(noc_pkg::noc_hdr_t hdr);
        noc_pkg::byte_addr_t end_byte;
        noc_pkg::byte_addr_t span;
        end_byte = hdr.addr + noc_pkg::byte_addr_t'(hdr.byte_cnt) - 1'b1;
        span     = (end_byte >> mem_pkg::LANE_W) - (hdr.addr >> mem_pkg::LANE_W);
        return span[7:0] + 8'd1;
    endfunction

    assign in_hdr = in_flit;

    // ----------------------------------------------------------
    // Request state
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            words_left <= '0;
            first_q    <= 1'b0;
        end else if (store_hdr) begin
            words_left <= word_count(in_hdr);
            first_q    <= 1'b1;
        end else if (next_word) begin
            words_left <= words_left - 1'b1;
            first_q    <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (store_hdr) begin
            hdr_q     <= in_hdr;
            word_addr <= in_hdr.addr[mem_pkg::LANE_W +: $bits(mem_pkg::mem_addr_t)];
        end else if (next_word) begin
            word_addr <= word_addr + 1'b1;
        end
    end

    assign first_word = first_q;
    assign last_word  = words_left == 8'd1;

    // ----------------------------------------------------------
    // Byte enables
    // ----------------------------------------------------------
    assign last_byte  = hdr_q.addr + noc_pkg::byte_addr_t'(hdr_q.byte_cnt) - 1'b1;
    assign lo_lane    = hdr_q.addr[mem_pkg::LANE_W-1:0];
    assign hi_lane    = last_byte[mem_pkg::LANE_W-1:0];
    assign first_mask = mem_pkg::byte_en_t'('1) << lo_lane;
    assign last_mask  = mem_pkg::byte_en_t'('1)
                        >> (mem_pkg::lane_t'(mem_pkg::WORD_BYTES - 1) - hi_lane);

    always_comb begin
        mem_req.addr    = word_addr;
        mem_req.wr_data = in_flit;
        mem_req.byte_en = (first_q ? first_mask : '1) & (last_word ? last_mask : '1);
    end

    // ----------------------------------------------------------
    // Response headers
    // ----------------------------------------------------------
    // Node id 0 marks a request issued by this tile itself.
    assign dest_id = (hdr_q.node_id == '0) ? noc_pkg::NODE_ID : hdr_q.node_id;

    always_comb begin
        ld_resp_hdr          = hdr_q;
        ld_resp_hdr.msg_type = noc_pkg::MSG_LOAD_RESP;
        ld_resp_hdr.msg_len  = word_count(hdr_q);
        ld_resp_hdr.node_id  = dest_id;
        st_resp_hdr          = hdr_q;
        st_resp_hdr.msg_type = noc_pkg::MSG_STORE_RESP;
        st_resp_hdr.msg_len  = '0;
        st_resp_hdr.node_id  = dest_id;
    end

    assign resp_flit    = hdr_out ? noc_pkg::flit_t'(ld_resp_hdr) : mem_rd_data;
    assign wr_resp_flit = st_resp_hdr;

endmodule

`default_nettype wire

// ==== masked_mem_wr_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module masked_mem_wr_ctrl (
     input  logic   clk
    ,input  logic   arst_n

    ,input  logic   req_val
    ,output logic   req_rdy

    ,output logic   mem_write_en
    ,input  logic   mem_rdy

    ,output logic   wr_resp_val
    ,input  logic   wr_resp_rdy

    ,output logic   wr_in_progress

    ,output logic   store_hdr
    ,output logic   next_word
    ,input  logic   last_word
);
    typedef enum logic [1:0] {IDLE, WRITE, SEND_RESP} state_t;

    state_t state;
    state_t state_nxt;

    assign wr_in_progress = state != IDLE;

    always_comb begin
        req_rdy      = 1'b0;
        mem_write_en = 1'b0;
        wr_resp_val  = 1'b0;
        store_hdr    = 1'b0;
        next_word    = 1'b0;
        state_nxt    = state;
        case (state)
            IDLE: begin
                req_rdy = 1'b1;
                if (req_val) begin
                    store_hdr = 1'b1;
                    state_nxt = WRITE;
                end
            end
            WRITE: begin
                // The payload flit is consumed only when memory takes the write.
                mem_write_en = req_val;
                req_rdy      = mem_rdy;
                if (req_val && mem_rdy) begin
                    next_word = 1'b1;
                    if (last_word) begin
                        state_nxt = SEND_RESP;
                    end
                end
            end
            default: begin
                wr_resp_val = 1'b1;
                if (wr_resp_rdy) begin
                    state_nxt = IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    a_resp_hold: assert property (@(posedge clk) disable iff (!arst_n)
        wr_resp_val && !wr_resp_rdy |=> wr_resp_val);

endmodule

`default_nettype wire

// ==== masked_mem_rd_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module masked_mem_rd_ctrl (
     input  logic   clk
    ,input  logic   arst_n

    ,input  logic   req_val
    ,output logic   req_rdy

    ,output logic   resp_val
    ,input  logic   resp_rdy

    ,output logic   mem_read_en
    ,input  logic   mem_rdy
    ,input  logic   mem_rd_val
    ,output logic   mem_rd_rdy

    ,output logic   rd_in_progress

    ,output logic   store_hdr
    ,output logic   next_word
    ,output logic   hdr_out
    ,input  logic   last_word
);
    typedef enum logic [2:0] {IDLE, SEND_HDR, ISSUE_RD, WAIT_DATA, DONE} state_t;

    state_t state;
    state_t state_nxt;

    assign rd_in_progress = state != IDLE;

    always_comb begin
        req_rdy     = 1'b0;
        resp_val    = 1'b0;
        mem_read_en = 1'b0;
        mem_rd_rdy  = 1'b0;
        store_hdr   = 1'b0;
        next_word   = 1'b0;
        hdr_out     = 1'b0;
        state_nxt   = state;
        case (state)
            IDLE: begin
                req_rdy = 1'b1;
                if (req_val) begin
                    store_hdr = 1'b1;
                    state_nxt = SEND_HDR;
                end
            end
            SEND_HDR: begin
                resp_val = 1'b1;
                hdr_out  = 1'b1;
                if (resp_rdy) begin
                    state_nxt = ISSUE_RD;
                end
            end
            ISSUE_RD: begin
                mem_read_en = 1'b1;
                if (mem_rdy) begin
                    state_nxt = WAIT_DATA;
                end
            end
            WAIT_DATA: begin
                // Returned word goes straight out as a data flit.
                resp_val   = mem_rd_val;
                mem_rd_rdy = resp_rdy;
                if (mem_rd_val && resp_rdy) begin
                    next_word = 1'b1;
                    state_nxt = last_word ? DONE : ISSUE_RD;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // A new read waits until the previous word has been taken from memory.
    a_rd_one_outstanding: assert property (@(posedge clk) disable iff (!arst_n)
        mem_read_en |-> !mem_rd_val);

endmodule

`default_nettype wire

// ==== noc_msg_type_splitter.sv ====
`timescale 1ns/1ns
`default_nettype none

module noc_msg_type_splitter (
     input  logic               clk
    ,input  logic               arst_n

    ,input  logic               in_val
    ,input  noc_pkg::flit_t     in_flit
    ,output logic               in_rdy

    ,output logic               rd_val
    ,output noc_pkg::flit_t     rd_flit
    ,input  logic               rd_rdy

    ,output logic               wr_val
    ,output noc_pkg::flit_t     wr_flit
    ,input  logic               wr_rdy
);
    typedef enum logic [1:0] {IDLE, ROUTE_RD, ROUTE_WR, DROP} state_t;

    state_t             state;
    state_t             state_nxt;
    state_t             route;
    noc_pkg::msg_len_t  flits_left;
    noc_pkg::msg_len_t  flits_left_nxt;
    noc_pkg::noc_hdr_t  hdr;

    assign hdr     = in_flit;

    // Each side sees the flit only while the message is routed to it.
    assign rd_flit = rd_val ? in_flit : '0;
    assign wr_flit = wr_val ? in_flit : '0;

    always_comb begin
        rd_val         = 1'b0;
        wr_val         = 1'b0;
        in_rdy         = 1'b0;
        route          = DROP;
        state_nxt      = state;
        flits_left_nxt = flits_left;
        case (state)
            IDLE: begin
                if (hdr.msg_type == noc_pkg::MSG_LOAD) begin
                    rd_val = in_val;
                    in_rdy = rd_rdy;
                    route  = ROUTE_RD;
                end else if (hdr.msg_type == noc_pkg::MSG_STORE) begin
                    wr_val = in_val;
                    in_rdy = wr_rdy;
                    route  = ROUTE_WR;
                end else begin
                    in_rdy = 1'b1;
                end
                // Header-only messages leave the splitter idle.
                if (in_val && in_rdy && hdr.msg_len != '0) begin
                    state_nxt      = route;
                    flits_left_nxt = hdr.msg_len;
                end
            end
            ROUTE_RD: begin
                rd_val = in_val;
                in_rdy = rd_rdy;
            end
            ROUTE_WR: begin
                wr_val = in_val;
                in_rdy = wr_rdy;
            end
            default: begin
                in_rdy = 1'b1;
            end
        endcase
        if (state != IDLE && in_val && in_rdy) begin
            flits_left_nxt = flits_left - 1'b1;
            if (flits_left == 8'd1) begin
                state_nxt = IDLE;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            flits_left <= '0;
        end else begin
            state      <= state_nxt;
            flits_left <= flits_left_nxt;
        end
    end

    a_one_target: assert property (@(posedge clk) disable iff (!arst_n)
        !(rd_val && wr_val));

endmodule

`default_nettype wire

// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    localparam int WORD_BYTES = 8;
    localparam int LANE_W     = $clog2(WORD_BYTES);

    typedef logic [8*WORD_BYTES-1:0] mem_word_t;
    typedef logic [15:0]             mem_addr_t;
    typedef logic [WORD_BYTES-1:0]   byte_en_t;
    typedef logic [LANE_W-1:0]       lane_t;

    // One word access, 88 bits.
    typedef struct packed {
        mem_addr_t addr;
        mem_word_t wr_data;
        byte_en_t  byte_en;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== noc_pkg.sv ====
`default_nettype none

package noc_pkg;

    localparam int FLIT_W = 64;

    typedef logic [FLIT_W-1:0] flit_t;
    typedef logic [7:0]        msg_type_t;
    typedef logic [7:0]        msg_len_t;
    typedef logic [7:0]        node_id_t;
    typedef logic [7:0]        byte_cnt_t;
    typedef logic [31:0]       byte_addr_t;

    localparam msg_type_t MSG_LOAD       = 8'h11;
    localparam msg_type_t MSG_STORE      = 8'h12;
    localparam msg_type_t MSG_LOAD_RESP  = 8'h21;
    localparam msg_type_t MSG_STORE_RESP = 8'h22;

    // Header flit, most significant field first.
    typedef struct packed {
        msg_type_t  msg_type;
        msg_len_t   msg_len;
        node_id_t   node_id;
        byte_cnt_t  byte_cnt;
        byte_addr_t addr;
    } noc_hdr_t;

    localparam node_id_t NODE_ID = 8'h05;

endpackage

`default_nettype wire
